// File: Bender.yml
package:
  name: trdb

sources:
  - trdb_pkg.sv
  - trdb_branch_map.sv
  - trdb_packet_fifo.sv
  - trdb_stream_align.sv
  - trdb_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - trdb_top_props.sv
      - tb_trdb_top.sv

// File: filelist.f
trdb_pkg.sv
trdb_branch_map.sv
trdb_packet_fifo.sv
trdb_stream_align.sv
trdb_top.sv
tb_clock_gen.sv
trdb_top_props.sv
tb_trdb_top.sv

// File: tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset falls shortly after time zero so the asynchronous flops see an edge,
    // then stays low across the rising edges at 10 ns and 30 ns
    initial begin
        rst_no = 1'b1;
        #1 rst_no = 1'b0;
        #40 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_trdb_top.sv
// Trace stream testbench
`default_nettype none

module tb_trdb_top;

    timeunit 1ns;
    timeprecision 100ps;

    import trdb_pkg::*;

    // flushes are spaced so that a drain always ends before the next packet can close
    localparam int unsigned MIN_FLUSH_GAP = 40;
    localparam int unsigned DRAIN_LIMIT   = 200;

    logic  clk;
    logic  rst_n;
    logic  branch_valid;
    logic  branch_taken;
    logic  flush;
    word_t data;
    logic  valid;

    // expected stream, one entry per bit in the order it goes onto the wire
    bit                        exp_q[$];
    int unsigned               stream_len;
    int unsigned               word_count;
    int unsigned               since_flush;

    // mirror of the open branch map
    logic [COUNT_LEN-1:0]      m_count;
    logic [BRANCH_MAP_MAX-1:0] m_map;

    logic [31:0]               rng_state;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    trdb_top uut (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .branch_valid_i (branch_valid),
        .branch_taken_i (branch_taken),
        .flush_i        (flush),
        .data_o         (data),
        .valid_o        (valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // push n bits of value onto the expected stream, LSB first
    task automatic append_bits(input logic [63:0] value, input int unsigned n);
        for (int unsigned i = 0; i < n; i++) begin
            exp_q.push_back(value[i]);
        end
        stream_len += n;
    endtask

    // one sampled cycle of the branch map rules, then the flush padding
    task automatic model_step(input logic bv, input logic bt, input logic fl);
        logic [COUNT_LEN-1:0] count_next;
        int unsigned          pad;
        count_next = m_count + COUNT_LEN'(bv);
        if (bv && bt) begin
            m_map[m_count] = 1'b1;
        end
        if ((count_next == COUNT_LEN'(BRANCH_MAP_MAX)) || (fl && (count_next != '0))) begin
            // header counts format, count and one bit per branch
            append_bits(64'(FORMAT_LEN + COUNT_LEN + count_next), PACKET_HEADER_LEN);
            append_bits(64'(FORMAT_BRANCH_MAP), FORMAT_LEN);
            append_bits(64'(count_next), COUNT_LEN);
            append_bits(64'(m_map), count_next);
            m_map   = '0;
            m_count = '0;
        end else begin
            m_count = count_next;
        end
        // a flush zero-fills the stream up to the next word boundary
        if (fl) begin
            pad = (WORD_LEN - (stream_len % WORD_LEN)) % WORD_LEN;
            append_bits(64'd0, pad);
        end
    endtask

    // inputs change 2 ns after the rising edge and are sampled at the next one
    task automatic drive_cycle(input logic bv, input logic bt, input logic fl);
        @(posedge clk);
        #2;
        branch_valid = bv;
        branch_taken = bt;
        flush        = fl;
        model_step(bv, bt, fl);
        if (fl) begin
            since_flush = 0;
        end else begin
            since_flush++;
        end
    endtask

    // idle until every expected bit has been seen on data_o
    task automatic wait_stream_drained(input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while ((exp_q.size() != 0) && (cycles < limit)) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
            cycles++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout: %0d expected stream bits never reached data_o", exp_q.size());
            $display("RESULT: FAIL");
            $fatal(1, "drain timeout");
        end
    endtask

    // words are read at the falling edge, well away from the register updates
    always @(negedge clk) begin : check_words
        word_t exp_word;
        if (rst_n && valid) begin
            assert (exp_q.size() >= WORD_LEN) else begin
                $display("unexpected word %h on data_o with only %0d expected bits left",
                         data, exp_q.size());
                $display("RESULT: FAIL");
                $fatal(1, "unexpected output word");
            end
            for (int i = 0; i < WORD_LEN; i++) begin
                exp_word[i] = exp_q.pop_front();
            end
            assert (data === exp_word) else begin
                $display("Mismatch data_o: got %h expected %h", data, exp_word);
                $display("RESULT: FAIL");
                $fatal(1, "output word mismatch");
            end
            word_count++;
        end
    end

    // a failed bound property also ends the run
    always @(negedge clk) begin : watch_props
        assert (uut.u_props.fail_count == 0) else begin
            $display("bound property check failed %0d times", uut.u_props.fail_count);
            $display("RESULT: FAIL");
            $fatal(1, "property failure");
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic        fl;
        int unsigned cycles;

        branch_valid = 1'b0;
        branch_taken = 1'b0;
        flush        = 1'b0;
        stream_len   = 0;
        word_count   = 0;
        since_flush  = MIN_FLUSH_GAP;
        m_count      = '0;
        m_map        = '0;
        rng_state    = 32'd69934;

        // reset is still asserted at the first rising edge, so look from there on
        cycles = 0;
        while (((cycles == 0) || (rst_n !== 1'b1)) && (cycles < 10)) begin
            @(posedge clk);
            cycles++;
        end
        assert (rst_n === 1'b1) else begin
            $display("reset was never released");
            $display("RESULT: FAIL");
            $fatal(1, "reset timeout");
        end

        // a branch every cycle fills 31-branch maps back to back
        for (int i = 0; i < 300; i++) begin
            r = next_random();
            drive_cycle(1'b1, r[0], 1'b0);
        end

        // sparse branches with random flushes give short packets of many lengths
        for (int i = 0; i < 1500; i++) begin
            r  = next_random();
            fl = (since_flush >= MIN_FLUSH_GAP) && (r[11:8] == 4'd0);
            drive_cycle(r[1:0] != 2'b00, r[2], fl);
        end

        // a full map followed at once by a flush that carries its own branch,
        // so two packets are queued ahead of the tail word
        repeat (MIN_FLUSH_GAP) drive_cycle(1'b0, 1'b0, 1'b0);
        for (int i = 0; i < BRANCH_MAP_MAX; i++) begin
            r = next_random();
            drive_cycle(1'b1, r[0], 1'b0);
        end
        drive_cycle(1'b1, 1'b1, 1'b1);
        wait_stream_drained(DRAIN_LIMIT);

        // nothing open and nothing pending, so this flush must stay silent
        repeat (MIN_FLUSH_GAP) drive_cycle(1'b0, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b1);
        repeat (MIN_FLUSH_GAP) drive_cycle(1'b0, 1'b0, 1'b0);

        // a last short map closed by the final flush
        for (int i = 0; i < 5; i++) begin
            r = next_random();
            drive_cycle(1'b1, r[0], 1'b0);
        end
        drive_cycle(1'b0, 1'b0, 1'b1);
        wait_stream_drained(DRAIN_LIMIT);

        // any stray word in this window is caught by the word checker
        repeat (MIN_FLUSH_GAP) drive_cycle(1'b0, 1'b0, 1'b0);

        if ((exp_q.size() == 0) && (word_count > 0) && (uut.u_props.fail_count == 0)) begin
            $display("%0d words checked", word_count);
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("stream incomplete: %0d words seen, %0d bits outstanding",
                     word_count, exp_q.size());
            $display("RESULT: FAIL");
            $fatal(1, "stream incomplete");
        end
    end

endmodule

`default_nettype wire

// File: trdb_branch_map.sv
// Branch map packet builder
`default_nettype none

module trdb_branch_map (
    input  wire                 clk_i,
    input  wire                 rst_ni,

    // one branch outcome per cycle at most
    input  wire                 branch_valid_i,
    input  wire                 branch_taken_i,

    // closes the open map early
    input  wire                 flush_i,

    output logic                pkt_valid_o,
    output trdb_pkg::packet_t   pkt_bits_o,
    output trdb_pkg::plen_t     pkt_len_o
);

    import trdb_pkg::*;

    // number of fixed payload bits in front of the branch bits
    localparam int unsigned FIXED_LEN = FORMAT_LEN + COUNT_LEN;

    // recorded branches, the first branch sits in bit 0
    logic [BRANCH_MAP_MAX-1:0] map_q;
    logic [COUNT_LEN-1:0]      count_q;

    // map and count with the branch of this cycle already included
    logic [BRANCH_MAP_MAX-1:0] map_inc;
    logic [BRANCH_MAP_MAX-1:0] taken_vec;
    logic [COUNT_LEN-1:0]      count_inc;

    // set when the current cycle closes the map
    logic                      emit;

    // registered packet towards the FIFO
    logic                      pkt_valid_q;
    packet_t                   pkt_bits_q;
    plen_t                     pkt_len_q;

    // a taken branch lands at the position given by the current count
    assign taken_vec = BRANCH_MAP_MAX'(branch_valid_i & branch_taken_i) << count_q;
    assign map_inc   = map_q | taken_vec;
    assign count_inc = count_q + COUNT_LEN'(branch_valid_i);

    // the map closes when it is full, or on a flush if anything was recorded.
    // a branch in the flush cycle is already part of count_inc and map_inc
    assign emit = (count_inc == COUNT_LEN'(BRANCH_MAP_MAX)) ||
                  (flush_i && (count_inc != '0));

    // map and counter restart empty after each packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (emit) begin
            map_q   <= '0;
            count_q <= '0;
        end else begin
            map_q   <= map_inc;
            count_q <= count_inc;
        end
    end

    // push strobe is high for exactly one cycle per packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= emit;
        end
    end

    // payload layout from the LSB up: format, count, then the branch bits.
    // bits above the map are zero because map_inc is zero above the count
    always_ff @(posedge clk_i) begin
        if (emit) begin
            pkt_bits_q <= packet_t'({map_inc, count_inc, FORMAT_BRANCH_MAP});
            pkt_len_q  <= plen_t'(FIXED_LEN) + plen_t'(count_inc);
        end
    end

    assign pkt_valid_o = pkt_valid_q;
    assign pkt_bits_o  = pkt_bits_q;
    assign pkt_len_o   = pkt_len_q;

endmodule

`default_nettype wire

// File: trdb_packet_fifo.sv
// Trace packet FIFO
`default_nettype none

module trdb_packet_fifo (
    input  wire                 clk_i,
    input  wire                 rst_ni,

    // write side from the branch map, never blocked
    input  wire                 push_i,
    input  wire trdb_pkg::packet_t bits_i,
    input  wire trdb_pkg::plen_t   len_i,

    // read side, the head entry is always on the outputs
    input  wire                 pop_i,
    output logic                valid_o,
    output trdb_pkg::packet_t   bits_o,
    output trdb_pkg::plen_t     len_o
);

    import trdb_pkg::*;

    localparam int unsigned PTR_LEN = $clog2(PACKET_FIFO_DEPTH);

    // storage for payloads and their lengths
    packet_t            bits_mem [PACKET_FIFO_DEPTH];
    plen_t              len_mem  [PACKET_FIFO_DEPTH];

    logic [PTR_LEN-1:0] wr_ptr_q;
    logic [PTR_LEN-1:0] rd_ptr_q;

    // occupancy needs one bit more than the pointers to tell full from empty
    logic [PTR_LEN:0]   count_q;

    logic               do_pop;

    // a pop on an empty buffer is ignored so the occupancy cannot wrap
    assign do_pop = pop_i && (count_q != '0);

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop in the same cycle leave the occupancy unchanged
            case ({push_i, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // written entries become visible at the head in the next cycle
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            bits_mem[wr_ptr_q] <= bits_i;
            len_mem[wr_ptr_q]  <= len_i;
        end
    end

    assign valid_o = (count_q != '0);
    assign bits_o  = bits_mem[rd_ptr_q];
    assign len_o   = len_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: trdb_pkg.sv
// Trace debug shared definitions
`default_nettype none

package trdb_pkg;

    // payload bus width, wide enough for the largest branch-map payload of 38 bits
    localparam int unsigned PACKET_LEN = 64;

    // the length header counts payload bits only, the header itself is not included
    localparam int unsigned PACKET_HEADER_LEN = 7;

    // header plus payload as one flat vector, header in the low bits
    localparam int unsigned PACKET_TOTAL_LEN = PACKET_LEN + PACKET_HEADER_LEN;

    // width of the words handed to the trace memory or port
    localparam int unsigned WORD_LEN = 32;

    // a map is closed once this many branches have been recorded
    localparam int unsigned BRANCH_MAP_MAX = 31;

    // format field sits in the lowest payload bits
    localparam int unsigned FORMAT_LEN = 2;
    localparam logic [FORMAT_LEN-1:0] FORMAT_BRANCH_MAP = 2'b01;

    // branch count follows the format field
    localparam int unsigned COUNT_LEN = 5;

    // number of packets the FIFO holds between branch map and aligner
    localparam int unsigned PACKET_FIFO_DEPTH = 4;

    // one packet payload, LSB is sent first
    typedef logic [PACKET_LEN-1:0] packet_t;

    // payload length in bits
    typedef logic [PACKET_HEADER_LEN-1:0] plen_t;

    // one output word
    typedef logic [WORD_LEN-1:0] word_t;

endpackage

`default_nettype wire

// File: trdb_stream_align.sv
// Trace stream word aligner
`default_nettype none

module trdb_stream_align (
    input  wire                 clk_i,
    input  wire                 rst_ni,

    // head packet of the FIFO
    input  wire trdb_pkg::packet_t packet_bits_i,
    input  wire trdb_pkg::plen_t   packet_len_i,
    input  wire                 valid_i,
    output logic                grant_o,

    // request to pad and emit the last partial word
    input  wire                 flush_i,

    output trdb_pkg::word_t     data_o,
    output logic                valid_o
);

    import trdb_pkg::*;

    // read pointer covers header plus the largest payload
    localparam int unsigned PTR_LEN  = PACKET_HEADER_LEN + 1;
    localparam int unsigned FILL_LEN = $clog2(WORD_LEN);
    localparam int unsigned CNT_LEN  = FILL_LEN + 1;
    localparam int unsigned MASK_LEN = WORD_LEN + 1;

    typedef enum logic [1:0] {
        IDLE,
        READING,
        DRAIN
    } state_e;

    state_e                      state_q, state_d;

    // header and payload of the head packet as one stream, header first
    logic [PACKET_TOTAL_LEN-1:0] stream_vec;
    logic [PACKET_TOTAL_LEN-1:0] stream_shift;

    logic [PTR_LEN-1:0]          rd_ptr_q, rd_ptr_d;
    logic [PTR_LEN-1:0]          total_len;
    logic [PTR_LEN-1:0]          remain;

    // bits still missing from the word, bits taken this cycle and the new fill
    logic [CNT_LEN-1:0]          need;
    logic [CNT_LEN-1:0]          take;
    logic [CNT_LEN-1:0]          fill_sum;
    logic [MASK_LEN-1:0]         take_mask;

    // pending bits that do not yet make a word, zero above the fill count
    logic [WORD_LEN-2:0]         residual_q, residual_d;
    logic [FILL_LEN-1:0]         fill_q, fill_d;

    word_t                       chunk;
    word_t                       merged;
    logic                        done;

    // flush seen and not yet served
    logic                        drain_q, drain_d, drain_clr;

    // registered output word
    word_t                       data_q, data_d;
    logic                        valid_q, valid_d;

    assign stream_vec   = {packet_bits_i, packet_len_i};
    assign total_len    = PTR_LEN'(PACKET_HEADER_LEN) + PTR_LEN'(packet_len_i);
    assign remain       = total_len - rd_ptr_q;
    assign need         = CNT_LEN'(WORD_LEN) - CNT_LEN'(fill_q);

    // take what completes the word, or what is left of the packet if that is less
    assign take         = (remain < PTR_LEN'(need)) ? CNT_LEN'(remain) : need;
    assign stream_shift = stream_vec >> rd_ptr_q;
    assign take_mask    = (MASK_LEN'(1) << take) - MASK_LEN'(1);
    assign chunk        = stream_shift[WORD_LEN-1:0] & take_mask[WORD_LEN-1:0];

    // new bits go on top of the residual, the sum never exceeds one word
    assign merged       = {1'b0, residual_q} | (chunk << fill_q);
    assign fill_sum     = CNT_LEN'(fill_q) + take;
    assign done         = (PTR_LEN'(take) == remain);

    always_comb begin
        state_d    = state_q;
        rd_ptr_d   = rd_ptr_q;
        residual_d = residual_q;
        fill_d     = fill_q;
        data_d     = merged;
        valid_d    = 1'b0;
        grant_o    = 1'b0;
        drain_clr  = 1'b0;

        if (valid_i) begin
            // a packet is on offer, so keep packing whatever the state
            if (fill_sum == CNT_LEN'(WORD_LEN)) begin
                valid_d    = 1'b1;
                residual_d = '0;
                fill_d     = '0;
            end else begin
                residual_d = merged[WORD_LEN-2:0];
                fill_d     = fill_sum[FILL_LEN-1:0];
            end
            // pop the head once its last bit has been taken
            if (done) begin
                grant_o  = 1'b1;
                rd_ptr_d = '0;
                state_d  = IDLE;
            end else begin
                rd_ptr_d = rd_ptr_q + PTR_LEN'(take);
                state_d  = READING;
            end
        end else if (state_q == DRAIN) begin
            // FIFO still empty one cycle on, so the flushed packet is already packed
            data_d     = {1'b0, residual_q};
            valid_d    = (fill_q != '0);
            residual_d = '0;
            fill_d     = '0;
            drain_clr  = 1'b1;
            state_d    = IDLE;
        end else if ((state_q == IDLE) && drain_q) begin
            // wait one cycle so that a packet closed by the flush reaches the head
            state_d = DRAIN;
        end
    end

    // a flush during the drain cycle arms the next drain
    assign drain_d = (drain_q && !drain_clr) || flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            rd_ptr_q   <= '0;
            residual_q <= '0;
            fill_q     <= '0;
            drain_q    <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            state_q    <= state_d;
            rd_ptr_q   <= rd_ptr_d;
            residual_q <= residual_d;
            fill_q     <= fill_d;
            drain_q    <= drain_d;
            valid_q    <= valid_d;
        end
    end

    // word content only matters while valid_q is high
    always_ff @(posedge clk_i) begin
        if (valid_d) begin
            data_q <= data_d;
        end
    end

    assign data_o  = data_q;
    assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: trdb_top.sv
// Trace debug branch stream top
`default_nettype none

module trdb_top (
    input  wire                 clk_i,
    input  wire                 rst_ni,

    // branch outcomes from the core, sampled every cycle
    input  wire                 branch_valid_i,
    input  wire                 branch_taken_i,

    // closes the open map and pads the last word
    input  wire                 flush_i,

    // packed trace words, no back-pressure
    output trdb_pkg::word_t     data_o,
    output logic                valid_o
);

    import trdb_pkg::*;

    // branch map to FIFO
    logic    pkt_valid;
    packet_t pkt_bits;
    plen_t   pkt_len;

    // FIFO head to aligner
    logic    fifo_valid;
    packet_t fifo_bits;
    plen_t   fifo_len;
    logic    grant;

    trdb_branch_map i_branch_map (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .branch_valid_i (branch_valid_i),
        .branch_taken_i (branch_taken_i),
        .flush_i        (flush_i),
        .pkt_valid_o    (pkt_valid),
        .pkt_bits_o     (pkt_bits),
        .pkt_len_o      (pkt_len)
    );

    // the FIFO has no full flag since the aligner drains far faster than it fills
    trdb_packet_fifo i_packet_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (pkt_valid),
        .bits_i  (pkt_bits),
        .len_i   (pkt_len),
        .pop_i   (grant),
        .valid_o (fifo_valid),
        .bits_o  (fifo_bits),
        .len_o   (fifo_len)
    );

    // the flush also reaches the aligner so it can pad the tail word
    trdb_stream_align i_stream_align (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .packet_bits_i (fifo_bits),
        .packet_len_i  (fifo_len),
        .valid_i       (fifo_valid),
        .grant_o       (grant),
        .flush_i       (flush_i),
        .data_o        (data_o),
        .valid_o       (valid_o)
    );

endmodule

`default_nettype wire

// File: trdb_top_props.sv
// Trace stream bound checks
`default_nettype none

module trdb_top_props (
    input wire clk_i,
    input wire rst_ni,
    input wire valid_i,
    input wire push_i,
    input wire grant_i,
    input wire fifo_valid_i,
    input wire [$clog2(trdb_pkg::PACKET_FIFO_DEPTH):0] fifo_count_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import trdb_pkg::*;

    // number of failed properties, watched by the testbench
    int unsigned fail_count = 0;

    // no word may leave the aligner while reset is held
    valid_low_in_reset: assert property (
        @(posedge clk_i) !rst_ni |-> !valid_i
    ) else begin
        fail_count++;
        $error("valid_o high during reset");
    end

    // the FIFO has no full flag, so a push into a full buffer would lose a packet
    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push_i |-> (fifo_count_i < PACKET_FIFO_DEPTH)
    ) else begin
        fail_count++;
        $error("packet pushed into a full FIFO");
    end

    // the aligner only pops a packet it can actually see
    no_grant_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        grant_i |-> fifo_valid_i
    ) else begin
        fail_count++;
        $error("grant raised while the FIFO is empty");
    end

endmodule

// attached to every trdb_top, the FIFO occupancy is taken from inside the instance
bind trdb_top trdb_top_props u_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid_o),
    .push_i       (pkt_valid),
    .grant_i      (grant),
    .fifo_valid_i (fifo_valid),
    .fifo_count_i (i_packet_fifo.count_q)
);

`default_nettype wire
